//--- Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_l1d
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // Controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WB_REQ,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_RESPOND
    } ctrl_state_t;

    // Associativity used by the top level unless overridden
    localparam int DEFAULT_WAYS = 4;

endpackage

//--- cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int ADDR_BITS       = 32;
    localparam int WORD_BITS       = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_BITS      = WORD_BITS * WORDS_PER_BLOCK;
    localparam int OFFSET_BITS     = 4;
    localparam int BYTE_BITS       = 2;
    localparam int WORD_SEL_BITS   = 2;
    localparam int SET_BITS        = 4;
    localparam int NUM_SETS        = 1 << SET_BITS;
    localparam int TAG_BITS        = 24;

    typedef logic [ADDR_BITS-1:0]     addr_t;
    typedef logic [WORD_BITS-1:0]     word_t;
    // Word 0 sits in the low bits
    typedef logic [BLOCK_BITS-1:0]    block_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [SET_BITS-1:0]      set_idx_t;
    typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

    // Address layout: tag | set | word select | byte offset
    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic set_idx_t addr_set(addr_t addr);
        return addr[OFFSET_BITS +: SET_BITS];
    endfunction

    function automatic word_sel_t addr_word(addr_t addr);
        return addr[BYTE_BITS +: WORD_SEL_BITS];
    endfunction

    function automatic addr_t block_addr(tag_t tag, set_idx_t set_idx);
        return {tag, set_idx, {OFFSET_BITS{1'b0}}};
    endfunction

endpackage

//--- cache_store.sv
`timescale 1ns/100ps

module cache_store import cache_geom_pkg::*; #(
    parameter int NUM_WAYS = 4,
    parameter int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  addr_t               addr_i,
    input  word_t               wdata_i,
    input  logic [WAY_BITS-1:0] way_i,
    input  logic                word_we_i,
    input  logic                fill_we_i,
    input  block_t              fill_block_i,

    output logic                hit_o,
    output logic [WAY_BITS-1:0] hit_way_o,
    output word_t               hit_word_o,
    output logic [NUM_WAYS-1:0] set_valid_o,
    output logic                sel_valid_o,
    output logic                sel_dirty_o,
    output tag_t                sel_tag_o,
    output block_t              sel_block_o
);

    tag_t                tag_q   [NUM_SETS][NUM_WAYS];
    block_t              data_q  [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];

    set_idx_t            set_idx;
    tag_t                req_tag;
    word_sel_t           word_sel;
    logic [NUM_WAYS-1:0] hit_vec;

    assign set_idx  = addr_set(addr_i);
    assign req_tag  = addr_tag(addr_i);
    assign word_sel = addr_word(addr_i);

    // Tag compare across all ways of the addressed set
    always_comb begin
        hit_vec   = '0;
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[set_idx][w] && tag_q[set_idx][w] == req_tag) begin
                hit_vec[w] = 1'b1;
                hit_o      = 1'b1;
                hit_way_o  = WAY_BITS'(w);
            end
        end
    end

    assign hit_word_o = data_q[set_idx][hit_way_o][word_sel * WORD_BITS +: WORD_BITS];

    // Way picked by the controller, used for eviction
    assign set_valid_o = valid_q[set_idx];
    assign sel_valid_o = valid_q[set_idx][way_i];
    assign sel_dirty_o = dirty_q[set_idx][way_i];
    assign sel_tag_o   = tag_q[set_idx][way_i];
    assign sel_block_o = data_q[set_idx][way_i];

    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            tag_q[set_idx][way_i]  <= req_tag;
            data_q[set_idx][way_i] <= fill_block_i;
        end else if (word_we_i) begin
            data_q[set_idx][way_i][word_sel * WORD_BITS +: WORD_BITS] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill_we_i) begin
            valid_q[set_idx][way_i] <= 1'b1;
            dirty_q[set_idx][way_i] <= 1'b0;
        end else if (word_we_i) begin
            dirty_q[set_idx][way_i] <= 1'b1;
        end
    end

    // A block is never present in two ways of one set
    assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(hit_vec))
        else $error("multiple ways hit in set %0d", set_idx);

endmodule

//--- l1d_fsm.sv
`timescale 1ns/100ps

module l1d_fsm import cache_geom_pkg::*, cache_ctrl_pkg::*; #(
    parameter int NUM_WAYS = 4,
    parameter int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  logic                req_valid_i,
    input  logic                req_write_i,
    input  addr_t               req_addr_i,
    input  word_t               req_wdata_i,
    output logic                req_ready_o,

    output logic                resp_valid_o,
    output word_t               resp_rdata_o,
    input  logic                resp_ready_i,

    output logic                bus_req_valid_o,
    output logic                bus_req_write_o,
    output addr_t               bus_req_addr_o,
    output block_t              bus_req_wdata_o,
    input  logic                bus_req_ready_i,

    input  logic                bus_rdata_valid_i,
    input  block_t              bus_rdata_i,
    output logic                bus_rdata_ready_o,

    input  logic                lookup_hit_i,
    input  logic [WAY_BITS-1:0] lookup_way_i,
    input  word_t               lookup_word_i,
    input  logic [WAY_BITS-1:0] victim_way_i,
    input  logic                victim_valid_i,
    input  logic                victim_dirty_i,
    input  tag_t                victim_tag_i,
    input  block_t              victim_block_i,

    output addr_t               req_addr_o,
    output word_t               wdata_o,
    output logic [WAY_BITS-1:0] way_o,
    output logic                word_we_o,
    output logic                fill_we_o,
    output block_t              fill_block_o
);

    ctrl_state_t         state_q;
    logic                resp_valid_q;
    logic                bus_req_valid_q;

    addr_t               req_addr_q;
    word_t               req_wdata_q;
    logic                req_write_q;
    word_t               resp_rdata_q;
    logic                bus_req_write_q;
    addr_t               bus_req_addr_q;
    block_t              bus_req_wdata_q;
    logic [WAY_BITS-1:0] victim_way_q;

    logic                req_fire;
    logic                evict_dirty;
    addr_t               fill_addr;
    addr_t               wb_addr;

    assign req_fire    = req_valid_i && req_ready_o;
    assign evict_dirty = victim_valid_i && victim_dirty_i;
    assign fill_addr   = block_addr(addr_tag(req_addr_q), addr_set(req_addr_q));
    assign wb_addr     = block_addr(victim_tag_i, addr_set(req_addr_q));

    assign req_ready_o       = (state_q == ST_IDLE);
    assign bus_rdata_ready_o = (state_q == ST_FILL_WAIT);
    assign resp_valid_o      = resp_valid_q;
    assign resp_rdata_o      = resp_rdata_q;
    assign bus_req_valid_o   = bus_req_valid_q;
    assign bus_req_write_o   = bus_req_write_q;
    assign bus_req_addr_o    = bus_req_addr_q;
    assign bus_req_wdata_o   = bus_req_wdata_q;

    assign req_addr_o   = req_addr_q;
    assign wdata_o      = req_wdata_q;
    assign word_we_o    = (state_q == ST_LOOKUP) && lookup_hit_i && req_write_q;
    assign fill_we_o    = (state_q == ST_FILL_WAIT) && bus_rdata_valid_i;
    assign fill_block_o = bus_rdata_i;

    // During lookup the store shows the candidate victim; later the latched one
    always_comb begin
        if (state_q == ST_LOOKUP) begin
            way_o = lookup_hit_i ? lookup_way_i : victim_way_i;
        end else begin
            way_o = victim_way_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q         <= ST_IDLE;
            resp_valid_q    <= 1'b0;
            bus_req_valid_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_fire) state_q <= ST_LOOKUP;
                end
                ST_LOOKUP: begin
                    if (lookup_hit_i && req_write_q) begin
                        state_q <= ST_IDLE;
                    end else if (lookup_hit_i) begin
                        resp_valid_q <= 1'b1;
                        state_q      <= ST_RESPOND;
                    end else begin
                        bus_req_valid_q <= 1'b1;
                        state_q         <= evict_dirty ? ST_WB_REQ : ST_FILL_REQ;
                    end
                end
                ST_WB_REQ: begin
                    // Request stays valid, the fill read follows directly
                    if (bus_req_ready_i) state_q <= ST_FILL_REQ;
                end
                ST_FILL_REQ: begin
                    if (bus_req_ready_i) begin
                        bus_req_valid_q <= 1'b0;
                        state_q         <= ST_FILL_WAIT;
                    end
                end
                ST_FILL_WAIT: begin
                    if (bus_rdata_valid_i) state_q <= ST_LOOKUP;
                end
                ST_RESPOND: begin
                    if (resp_ready_i) begin
                        resp_valid_q <= 1'b0;
                        state_q      <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_addr_q  <= req_addr_i;
            req_wdata_q <= req_wdata_i;
            req_write_q <= req_write_i;
        end
        if (state_q == ST_LOOKUP && lookup_hit_i) begin
            resp_rdata_q <= lookup_word_i;
        end
        if (state_q == ST_LOOKUP && !lookup_hit_i) begin
            victim_way_q    <= victim_way_i;
            bus_req_write_q <= evict_dirty;
            bus_req_addr_q  <= evict_dirty ? wb_addr : fill_addr;
            bus_req_wdata_q <= victim_block_i;
        end
        if (state_q == ST_WB_REQ && bus_req_ready_i) begin
            bus_req_write_q <= 1'b0;
            bus_req_addr_q  <= fill_addr;
        end
    end

    // Bus request held until the bus takes it
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o
            && $stable(bus_req_write_o) && $stable(bus_req_addr_o)
            && $stable(bus_req_wdata_o))
        else $error("bus request changed before ready");

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o |-> state_q == ST_RESPOND)
        else $error("response valid outside respond state");

endmodule

//--- l1d_top.sv
`timescale 1ns/100ps

module l1d_top import cache_geom_pkg::*, cache_ctrl_pkg::*; #(
    parameter int NUM_WAYS = DEFAULT_WAYS
) (
    input  logic   clk_i,
    input  logic   rstn_i,

    input  logic   req_valid_i,
    input  logic   req_write_i,
    input  addr_t  req_addr_i,
    input  word_t  req_wdata_i,
    output logic   req_ready_o,

    output logic   resp_valid_o,
    output word_t  resp_rdata_o,
    input  logic   resp_ready_i,

    output logic   bus_req_valid_o,
    output logic   bus_req_write_o,
    output addr_t  bus_req_addr_o,
    output block_t bus_req_wdata_o,
    input  logic   bus_req_ready_i,

    input  logic   bus_rdata_valid_i,
    input  block_t bus_rdata_i,
    output logic   bus_rdata_ready_o
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    addr_t               req_addr;
    word_t               wdata;
    logic [WAY_BITS-1:0] way;
    logic                word_we;
    logic                fill_we;
    block_t              fill_block;
    logic                lookup_hit;
    logic [WAY_BITS-1:0] lookup_way;
    word_t               lookup_word;
    logic [NUM_WAYS-1:0] set_valid;
    logic [WAY_BITS-1:0] victim_way;
    logic                victim_valid;
    logic                victim_dirty;
    tag_t                victim_tag;
    block_t              victim_block;

    l1d_fsm #(.NUM_WAYS(NUM_WAYS)) u_fsm (
        .clk_i, .rstn_i,
        .req_valid_i, .req_write_i, .req_addr_i, .req_wdata_i, .req_ready_o,
        .resp_valid_o, .resp_rdata_o, .resp_ready_i,
        .bus_req_valid_o, .bus_req_write_o, .bus_req_addr_o, .bus_req_wdata_o,
        .bus_req_ready_i,
        .bus_rdata_valid_i, .bus_rdata_i, .bus_rdata_ready_o,
        .lookup_hit_i   (lookup_hit),
        .lookup_way_i   (lookup_way),
        .lookup_word_i  (lookup_word),
        .victim_way_i   (victim_way),
        .victim_valid_i (victim_valid),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_block_i (victim_block),
        .req_addr_o     (req_addr),
        .wdata_o        (wdata),
        .way_o          (way),
        .word_we_o      (word_we),
        .fill_we_o      (fill_we),
        .fill_block_o   (fill_block)
    );

    cache_store #(.NUM_WAYS(NUM_WAYS)) u_store (
        .clk_i, .rstn_i,
        .addr_i       (req_addr),
        .wdata_i      (wdata),
        .way_i        (way),
        .word_we_i    (word_we),
        .fill_we_i    (fill_we),
        .fill_block_i (fill_block),
        .hit_o        (lookup_hit),
        .hit_way_o    (lookup_way),
        .hit_word_o   (lookup_word),
        .set_valid_o  (set_valid),
        .sel_valid_o  (victim_valid),
        .sel_dirty_o  (victim_dirty),
        .sel_tag_o    (victim_tag),
        .sel_block_o  (victim_block)
    );

    victim_select #(.NUM_WAYS(NUM_WAYS)) u_victim (
        .clk_i, .rstn_i,
        .set_valid_i  (set_valid),
        .victim_way_o (victim_way)
    );

endmodule

//--- list.f
cache_geom_pkg.sv
cache_ctrl_pkg.sv
cache_store.sv
victim_select.sv
l1d_fsm.sv
l1d_top.sv
tb_l1d.sv

//--- tb_l1d.sv
`timescale 1ns/100ps

module tb_l1d import cache_geom_pkg::*; ();

    localparam int   N_OPS          = 40;
    localparam int   TIMEOUT_CYCLES = N_OPS * 60;
    localparam logic RD             = 1'b0;
    localparam logic WR             = 1'b1;

    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t data;
    } op_t;

    // Set 3 and set 7 each see more blocks than there are ways
    localparam op_t OP_TABLE [N_OPS] = '{
        {RD, 32'h0000_0100, 32'h0}, {RD, 32'h0000_0104, 32'h0},
        {WR, 32'h0000_0108, 32'hA5A5_0108}, {RD, 32'h0000_0108, 32'h0},
        {WR, 32'h0000_0030, 32'h1111_0030}, {WR, 32'h0000_1034, 32'h2222_1034},
        {WR, 32'h0000_2038, 32'h3333_2038}, {WR, 32'h0001_003C, 32'h4444_003C},
        {RD, 32'h0000_0030, 32'h0}, {WR, 32'h0ABC_0030, 32'h5555_0030},
        {WR, 32'h0000_3034, 32'h6666_3034}, {RD, 32'h0000_4030, 32'h0},
        {RD, 32'h0000_1034, 32'h0}, {RD, 32'h0000_2038, 32'h0},
        {RD, 32'h0001_003C, 32'h0}, {RD, 32'h0000_0030, 32'h0},
        {WR, 32'h0000_0034, 32'h7777_0034}, {RD, 32'h0ABC_0030, 32'h0},
        {RD, 32'h0000_3034, 32'h0}, {WR, 32'h0000_5030, 32'h8888_5030},
        {WR, 32'h0000_6030, 32'h9999_6030}, {RD, 32'h0000_0034, 32'h0},
        {RD, 32'h0000_0030, 32'h0}, {WR, 32'h0000_0070, 32'hC0C0_0070},
        {WR, 32'h1000_0074, 32'hC1C1_0074}, {WR, 32'h2000_0078, 32'hC2C2_0078},
        {WR, 32'h3000_007C, 32'hC3C3_007C}, {WR, 32'h4000_0070, 32'hC4C4_0070},
        {RD, 32'h5000_0074, 32'h0}, {RD, 32'h0000_0070, 32'h0},
        {RD, 32'h1000_0074, 32'h0}, {WR, 32'h0000_0104, 32'hDEAD_0104},
        {RD, 32'h0000_0104, 32'h0}, {RD, 32'h2000_0078, 32'h0},
        {RD, 32'h3000_007C, 32'h0}, {RD, 32'h4000_0070, 32'h0},
        {RD, 32'h0000_5030, 32'h0}, {RD, 32'h0000_6030, 32'h0},
        {RD, 32'h0ABC_0030, 32'h0}, {RD, 32'h0000_FFF0, 32'h0}
    };

    logic   clk_i;
    logic   rstn_i;
    logic   req_valid_i;
    logic   req_write_i;
    addr_t  req_addr_i;
    word_t  req_wdata_i;
    logic   req_ready_o;
    logic   resp_valid_o;
    word_t  resp_rdata_o;
    logic   resp_ready_i;
    logic   bus_req_valid_o;
    logic   bus_req_write_o;
    addr_t  bus_req_addr_o;
    block_t bus_req_wdata_o;
    logic   bus_req_ready_i;
    logic   bus_rdata_valid_i;
    block_t bus_rdata_i;
    logic   bus_rdata_ready_o;

    int     seed = 8;
    addr_t  cur_addr;
    // Backing memory and expected contents, keyed by word address
    word_t  mem  [addr_t];
    word_t  gold [addr_t];

    l1d_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic word_t preset_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h9E37_79B9;
    endfunction

    function automatic word_t golden_word(addr_t a);
        return gold.exists(a) ? gold[a] : preset_word(a);
    endfunction

    function automatic word_t memory_word(addr_t a);
        return mem.exists(a) ? mem[a] : preset_word(a);
    endfunction

    function automatic block_t golden_block(addr_t a);
        block_t blk;
        for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
            blk[w*WORD_BITS +: WORD_BITS] = golden_word(a + addr_t'(4 * w));
        end
        return blk;
    endfunction

    function automatic block_t memory_block(addr_t a);
        block_t blk;
        for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
            blk[w*WORD_BITS +: WORD_BITS] = memory_word(a + addr_t'(4 * w));
        end
        return blk;
    endfunction

    task automatic report_failure(string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                     $time, what, got, exp));
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
    endtask

    task automatic check_block(block_t got, block_t exp, string what);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp)
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
    endtask

    // Bus memory model plus random stalls on resp_ready_i and the bus
    initial begin : responder
        logic  rd_pending;
        logic  rd_taken;
        int    rd_delay;
        addr_t rd_addr;
        rd_pending        = 1'b0;
        rd_taken          = 1'b0;
        rd_delay          = 0;
        rd_addr           = '0;
        resp_ready_i      = 1'b0;
        bus_req_ready_i   = 1'b0;
        bus_rdata_valid_i = 1'b0;
        bus_rdata_i       = '0;
        forever begin
            @(negedge clk_i);
            rd_taken = bus_rdata_valid_i && bus_rdata_ready_o;
            if (bus_req_valid_o && bus_req_ready_i) begin
                if (bus_req_write_o) begin
                    check_addr(bus_req_addr_o, {bus_req_addr_o[31:8], cur_addr[7:4], 4'h0},
                               "write-back address");
                    check_block(bus_req_wdata_o, golden_block(bus_req_addr_o),
                                "write-back data");
                    for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
                        mem[bus_req_addr_o + addr_t'(4 * w)] =
                            bus_req_wdata_o[w*WORD_BITS +: WORD_BITS];
                    end
                end else begin
                    check_addr(bus_req_addr_o, {cur_addr[31:4], 4'h0}, "fill address");
                    rd_pending = 1'b1;
                    rd_addr    = bus_req_addr_o;
                    rd_delay   = $random(seed) & 3;
                end
            end
            @(posedge clk_i);
            #2;
            bus_req_ready_i = ($random(seed) & 3) != 0;
            resp_ready_i    = ($random(seed) & 1) != 0;
            if (rd_taken) begin
                bus_rdata_valid_i = 1'b0;
                rd_pending        = 1'b0;
            end else if (rd_pending && !bus_rdata_valid_i) begin
                if (rd_delay == 0) begin
                    bus_rdata_valid_i = 1'b1;
                    bus_rdata_i       = memory_block(rd_addr);
                end else begin
                    rd_delay--;
                end
            end
        end
    end

    initial begin : stimulus
        word_t exp_word;
        int    lat;
        logic  bus_seen;
        rstn_i      = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        cur_addr    = '0;
        repeat (5) @(posedge clk_i);
        #2 rstn_i = 1'b1;
        @(negedge clk_i);
        check_bit(req_ready_o, 1'b1, "req_ready_o after reset");
        check_bit(resp_valid_o, 1'b0, "resp_valid_o after reset");
        check_bit(bus_req_valid_o, 1'b0, "bus_req_valid_o after reset");
        check_bit(bus_rdata_ready_o, 1'b0, "bus_rdata_ready_o after reset");

        for (int i = 0; i < N_OPS; i++) begin
            @(posedge clk_i);
            #2;
            req_valid_i = 1'b1;
            req_write_i = OP_TABLE[i].wr;
            req_addr_i  = OP_TABLE[i].addr;
            req_wdata_i = OP_TABLE[i].data;
            do @(negedge clk_i); while (!req_ready_o);
            // The controller is idle here, so the previous miss is complete
            cur_addr = OP_TABLE[i].addr;
            if (OP_TABLE[i].wr)
                gold[OP_TABLE[i].addr] = OP_TABLE[i].data;
            exp_word = golden_word(OP_TABLE[i].addr);
            @(posedge clk_i);
            #2 req_valid_i = 1'b0;
            if (!OP_TABLE[i].wr) begin
                lat      = 0;
                bus_seen = 1'b0;
                do begin
                    @(negedge clk_i);
                    lat++;
                    if (bus_req_valid_o) bus_seen = 1'b1;
                end while (!resp_valid_o);
                // A hit never touches the bus
                if (!bus_seen && lat != 2)
                    report_failure($sformatf(
                        "CHECK FAILED at %0t: read hit response after %0d cycles, expected 2",
                        $time, lat));
                check_bit(req_ready_o, 1'b0, "req_ready_o while response pending");
                while (!resp_ready_i) begin
                    @(negedge clk_i);
                    check_bit(req_ready_o, 1'b0, "req_ready_o while response pending");
                    check_bit(resp_valid_o, 1'b1, "resp_valid_o held");
                end
                check_word(resp_rdata_o, exp_word, "read data");
            end
        end

        do @(negedge clk_i); while (!req_ready_o);
        check_bit(bus_req_valid_o, 1'b0, "bus_req_valid_o at end");
        $display("STATUS: PASS");
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        report_failure($sformatf("Timeout: test did not finish within %0d cycles",
                                 TIMEOUT_CYCLES));
    end

endmodule

//--- victim_select.sv
`timescale 1ns/100ps

module victim_select #(
    parameter int NUM_WAYS = 4,
    parameter int WAY_BITS = $clog2(NUM_WAYS)
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic [NUM_WAYS-1:0] set_valid_i,
    output logic [WAY_BITS-1:0] victim_way_o
);

    logic [WAY_BITS-1:0] rr_q;

    // Free-running round-robin pointer
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_q <= '0;
        end else if (rr_q == WAY_BITS'(NUM_WAYS - 1)) begin
            rr_q <= '0;
        end else begin
            rr_q <= rr_q + 1'b1;
        end
    end

    // Lowest invalid way wins, else the pointer
    always_comb begin
        victim_way_o = rr_q;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid_i[w]) begin
                victim_way_o = WAY_BITS'(w);
            end
        end
    end

    // A set with a free way never evicts a valid block
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(&set_valid_i) |-> !set_valid_i[victim_way_o])
        else $error("victim way %0d is valid while the set has a free way", victim_way_o);

endmodule
